//--- common/div_sqrt_pkg.sv
//////////////////////////////
// Shared format codes, widths and operand structs
// for the divide and square-root operand preparation
//////////////////////////////

package div_sqrt_pkg;

   //////////////////////////////
   // Format selection
   //////////////////////////////

   // Encoding of the format select input
   typedef enum logic [1:0] {
      fmt_fp32    = 2'd0,
      fmt_fp64    = 2'd1,
      fmt_fp16    = 2'd2,
      fmt_fp16alt = 2'd3
   } fmt_sel_e;

   //////////////////////////////
   // Per-format field widths
   //////////////////////////////

   // IEEE single precision
   localparam int unsigned fp32_op_width      = 32;
   localparam int unsigned fp32_exp_width     = 8;
   localparam int unsigned fp32_mant_width    = 23;

   // IEEE double precision, the widest format and the internal layout
   localparam int unsigned fp64_op_width      = 64;
   localparam int unsigned fp64_exp_width     = 11;
   localparam int unsigned fp64_mant_width    = 52;

   // IEEE half precision
   localparam int unsigned fp16_op_width      = 16;
   localparam int unsigned fp16_exp_width     = 5;
   localparam int unsigned fp16_mant_width    = 10;

   // Alternate half precision, same exponent range as FP32
   localparam int unsigned fp16alt_op_width   = 16;
   localparam int unsigned fp16alt_exp_width  = 8;
   localparam int unsigned fp16alt_mant_width = 7;

   //////////////////////////////
   // Internal datapath widths
   //////////////////////////////

   // Operand port, sized for FP64
   localparam int unsigned op_w   = 64;
   // Unpacked exponent
   localparam int unsigned exp_w  = 11;
   // Mantissa without the hidden bit
   localparam int unsigned mant_w = 52;
   // Leading-zero count over mant_w+1 bits
   localparam int unsigned lzc_w  = 6;
   // Rounding mode
   localparam int unsigned rm_w   = 3;

   //////////////////////////////
   // Operand structs
   //////////////////////////////

   // One operand after field extraction, aligned to the FP64 layout
   typedef struct packed {
      logic              sign;
      logic [exp_w-1:0]  exp;
      // Hidden bit on top, then the left-aligned fraction
      logic [mant_w:0]   mant;
      logic              is_zero;
      logic              is_inf;
      logic              is_nan;
      // Fraction looks like a signaling NaN, only meaningful with is_nan
      logic              sig_nan_pattern;
   } unpacked_op_t;

   // Operand after normalization
   typedef struct packed {
      // One extra bit so denormal exponents can drop below one
      logic [exp_w:0]    exp;
      logic [mant_w:0]   mant;
   } norm_op_t;

   // Registered class flags for one operand
   typedef struct packed {
      logic zero;
      logic inf;
      logic nan;
   } op_class_t;

endpackage

//--- filelist.f
+incdir+test
common/div_sqrt_pkg.sv
normalize/lead_zero_count.sv
normalize/op_normalize.sv
src/fp_unpack.sv
src/operand_capture.sv
src/div_sqrt_prep.sv
test/tb_div_sqrt_prep.sv

//--- normalize/lead_zero_count.sv
//////////////////////////////
// Leading-zero counter with all-zero flag
//////////////////////////////

module lead_zero_count
#(
   // Expected to be at least 2
   parameter int unsigned width = 53
)
(
   input  logic [width-1:0]         bits,
   output logic [$clog2(width)-1:0] count,
   output logic                     empty
);

   localparam int unsigned count_w = $clog2(width);

   //////////////////////////////
   // Priority scan
   //////////////////////////////

   // Walk upward so the highest set bit is the last one to write the count
   always_comb
   begin
      count = '0;
      for (int unsigned i = 0; i < width; i++)
      begin
         if (bits[i])
         begin
            // Number of positions between bit i and the top
            count = count_w'(width - 1 - i);
         end
      end
   end

   // No bit set, count reads zero in that case
   assign empty = ~|bits;

endmodule

//--- normalize/op_normalize.sv
//////////////////////////////
// Mantissa normalization with exponent correction
//////////////////////////////

module op_normalize
(
   input  div_sqrt_pkg::unpacked_op_t unpacked,
   output div_sqrt_pkg::norm_op_t     normed
);

   logic [div_sqrt_pkg::lzc_w-1:0] lz_count;
   // Exponent widened by one bit before the subtraction
   logic [div_sqrt_pkg::exp_w:0]   exp_wide;
   logic [div_sqrt_pkg::exp_w:0]   lz_wide;

   //////////////////////////////
   // Leading-zero detection
   //////////////////////////////

   lead_zero_count #(
      .width ( div_sqrt_pkg::mant_w + 1 )
   ) u_lzc (
      .bits  ( unpacked.mant ),
      .count ( lz_count      ),
      .empty (               )
   );

   assign exp_wide = {1'b0, unpacked.exp};
   assign lz_wide  = {{(div_sqrt_pkg::exp_w + 1 - div_sqrt_pkg::lzc_w){1'b0}}, lz_count};

   //////////////////////////////
   // Shift and exponent fixup
   //////////////////////////////

   always_comb
   begin
      // Zero mantissa gives a zero count and passes through unchanged
      normed.mant = unpacked.mant << lz_count;
      // Denormal exponent field reads 0 but encodes 1, hence the +1
      normed.exp  = exp_wide - lz_wide + {{div_sqrt_pkg::exp_w{1'b0}}, (|lz_count)};
   end

endmodule

//--- src/div_sqrt_prep.sv
//////////////////////////////
// Operand preparation top level
//////////////////////////////

module div_sqrt_prep
(
   input  logic                          Clk_CI,
   input  logic                          Rst_RBI,
   // Operation strobes and the ready level of the iteration stage
   input  logic                          div_start,
   input  logic                          sqrt_start,
   input  logic                          ready,
   // Raw operands, narrow formats sit in the low bits
   input  logic [div_sqrt_pkg::op_w-1:0] operand_a,
   input  logic [div_sqrt_pkg::op_w-1:0] operand_b,
   input  logic [div_sqrt_pkg::rm_w-1:0] rm,
   input  div_sqrt_pkg::fmt_sel_e        fmt_sel,
   // Held results for the following stages
   output div_sqrt_pkg::op_class_t       class_a,
   output div_sqrt_pkg::op_class_t       class_b,
   output logic                          snan,
   output logic                          sign_z,
   output logic [div_sqrt_pkg::rm_w-1:0] rm_dly,
   output div_sqrt_pkg::norm_op_t        norm_a,
   output div_sqrt_pkg::norm_op_t        norm_b
);

   div_sqrt_pkg::unpacked_op_t unpacked_a;
   div_sqrt_pkg::unpacked_op_t unpacked_b;
   div_sqrt_pkg::norm_op_t     normed_a;
   div_sqrt_pkg::norm_op_t     normed_b;

   //////////////////////////////
   // Decode
   //////////////////////////////

   fp_unpack u_unpack_a (
      .operand  ( operand_a  ),
      .fmt_sel  ( fmt_sel    ),
      .unpacked ( unpacked_a )
   );

   fp_unpack u_unpack_b (
      .operand  ( operand_b  ),
      .fmt_sel  ( fmt_sel    ),
      .unpacked ( unpacked_b )
   );

   //////////////////////////////
   // Normalize
   //////////////////////////////

   op_normalize u_norm_a (
      .unpacked ( unpacked_a ),
      .normed   ( normed_a   )
   );

   op_normalize u_norm_b (
      .unpacked ( unpacked_b ),
      .normed   ( normed_b   )
   );

   //////////////////////////////
   // Capture
   //////////////////////////////

   // Single register stage, loads on accept
   operand_capture u_capture (
      .Clk_CI     ( Clk_CI     ),
      .Rst_RBI    ( Rst_RBI    ),
      .div_start  ( div_start  ),
      .sqrt_start ( sqrt_start ),
      .ready      ( ready      ),
      .unpacked_a ( unpacked_a ),
      .unpacked_b ( unpacked_b ),
      .normed_a   ( normed_a   ),
      .normed_b   ( normed_b   ),
      .rm         ( rm         ),
      .class_a    ( class_a    ),
      .class_b    ( class_b    ),
      .snan       ( snan       ),
      .sign_z     ( sign_z     ),
      .rm_dly     ( rm_dly     ),
      .norm_a     ( norm_a     ),
      .norm_b     ( norm_b     )
   );

endmodule

//--- src/fp_unpack.sv
//////////////////////////////
// Field extraction and classification of one operand
//////////////////////////////

module fp_unpack
(
   input  logic [div_sqrt_pkg::op_w-1:0] operand,
   input  div_sqrt_pkg::fmt_sel_e        fmt_sel,
   output div_sqrt_pkg::unpacked_op_t    unpacked
);

   // Raw fields, already moved into the FP64 positions
   logic                            sign;
   logic [div_sqrt_pkg::exp_w-1:0]  exp_field;
   logic [div_sqrt_pkg::mant_w-1:0] mant_field;
   // Exponent is all ones for the selected format
   logic                            exp_all_ones;
   logic                            hidden_bit;
   logic                            mant_zero;

   //////////////////////////////
   // Format decode
   //////////////////////////////

   always_comb
   begin
      // Unused high bits stay zero, narrow fractions get zero padding at the bottom
      sign         = 1'b0;
      exp_field    = '0;
      mant_field   = '0;
      exp_all_ones = 1'b0;
      case (fmt_sel)
         div_sqrt_pkg::fmt_fp32:
         begin
            sign = operand[div_sqrt_pkg::fp32_op_width-1];
            exp_field[div_sqrt_pkg::fp32_exp_width-1:0] =
               operand[div_sqrt_pkg::fp32_op_width-2:div_sqrt_pkg::fp32_mant_width];
            mant_field[div_sqrt_pkg::mant_w-1 -: div_sqrt_pkg::fp32_mant_width] =
               operand[div_sqrt_pkg::fp32_mant_width-1:0];
            exp_all_ones = &exp_field[div_sqrt_pkg::fp32_exp_width-1:0];
         end
         div_sqrt_pkg::fmt_fp64:
         begin
            sign = operand[div_sqrt_pkg::fp64_op_width-1];
            exp_field[div_sqrt_pkg::fp64_exp_width-1:0] =
               operand[div_sqrt_pkg::fp64_op_width-2:div_sqrt_pkg::fp64_mant_width];
            mant_field[div_sqrt_pkg::mant_w-1 -: div_sqrt_pkg::fp64_mant_width] =
               operand[div_sqrt_pkg::fp64_mant_width-1:0];
            exp_all_ones = &exp_field[div_sqrt_pkg::fp64_exp_width-1:0];
         end
         div_sqrt_pkg::fmt_fp16:
         begin
            sign = operand[div_sqrt_pkg::fp16_op_width-1];
            exp_field[div_sqrt_pkg::fp16_exp_width-1:0] =
               operand[div_sqrt_pkg::fp16_op_width-2:div_sqrt_pkg::fp16_mant_width];
            mant_field[div_sqrt_pkg::mant_w-1 -: div_sqrt_pkg::fp16_mant_width] =
               operand[div_sqrt_pkg::fp16_mant_width-1:0];
            exp_all_ones = &exp_field[div_sqrt_pkg::fp16_exp_width-1:0];
         end
         div_sqrt_pkg::fmt_fp16alt:
         begin
            sign = operand[div_sqrt_pkg::fp16alt_op_width-1];
            exp_field[div_sqrt_pkg::fp16alt_exp_width-1:0] =
               operand[div_sqrt_pkg::fp16alt_op_width-2:div_sqrt_pkg::fp16alt_mant_width];
            mant_field[div_sqrt_pkg::mant_w-1 -: div_sqrt_pkg::fp16alt_mant_width] =
               operand[div_sqrt_pkg::fp16alt_mant_width-1:0];
            exp_all_ones = &exp_field[div_sqrt_pkg::fp16alt_exp_width-1:0];
         end
         default:
         begin
            exp_all_ones = 1'b0;
         end
      endcase
   end

   //////////////////////////////
   // Hidden bit and class flags
   //////////////////////////////

   // Denormals and zeros have a cleared exponent, hence no hidden one
   assign hidden_bit = |exp_field;
   assign mant_zero  = ~|mant_field;

   always_comb
   begin
      unpacked.sign    = sign;
      unpacked.exp     = exp_field;
      unpacked.mant    = {hidden_bit, mant_field};
      unpacked.is_zero = ~hidden_bit & mant_zero;
      unpacked.is_inf  = exp_all_ones & mant_zero;
      unpacked.is_nan  = exp_all_ones & ~mant_zero;
      // Quiet bit clear with some payload left, works since fractions are left-aligned
      unpacked.sig_nan_pattern = ~mant_field[div_sqrt_pkg::mant_w-1]
                                 & (|mant_field[div_sqrt_pkg::mant_w-2:0]);
   end

endmodule

//--- src/operand_capture.sv
//////////////////////////////
// Capture registers for operands, sign, rounding mode
// and the signaling NaN flag
//////////////////////////////

module operand_capture
(
   input  logic                          Clk_CI,
   input  logic                          Rst_RBI,
   input  logic                          div_start,
   input  logic                          sqrt_start,
   input  logic                          ready,
   input  div_sqrt_pkg::unpacked_op_t    unpacked_a,
   input  div_sqrt_pkg::unpacked_op_t    unpacked_b,
   input  div_sqrt_pkg::norm_op_t        normed_a,
   input  div_sqrt_pkg::norm_op_t        normed_b,
   input  logic [div_sqrt_pkg::rm_w-1:0] rm,
   output div_sqrt_pkg::op_class_t       class_a,
   output div_sqrt_pkg::op_class_t       class_b,
   output logic                          snan,
   output logic                          sign_z,
   output logic [div_sqrt_pkg::rm_w-1:0] rm_dly,
   output div_sqrt_pkg::norm_op_t        norm_a,
   output div_sqrt_pkg::norm_op_t        norm_b
);

   logic                    accept;
   div_sqrt_pkg::op_class_t class_a_next;
   div_sqrt_pkg::op_class_t class_b_next;
   logic                    snan_next;
   logic                    sign_next;

   //////////////////////////////
   // Accept and next values
   //////////////////////////////

   // Either operation starts while the unit is free
   assign accept = ready & (div_start | sqrt_start);

   always_comb
   begin
      class_a_next.zero = unpacked_a.is_zero;
      class_a_next.inf  = unpacked_a.is_inf;
      class_a_next.nan  = unpacked_a.is_nan;
      class_b_next.zero = unpacked_b.is_zero;
      class_b_next.inf  = unpacked_b.is_inf;
      class_b_next.nan  = unpacked_b.is_nan;
   end

   // Pattern only counts on an actual NaN
   assign snan_next = (unpacked_a.is_nan & unpacked_a.sig_nan_pattern)
                      | (unpacked_b.is_nan & unpacked_b.sig_nan_pattern);

   // Divide takes priority when both starts come together
   always_comb
   begin
      if (div_start)
      begin
         sign_next = unpacked_a.sign ^ unpacked_b.sign;
      end
      else
      begin
         // Square root keeps the radicand sign, negative inputs caught later
         sign_next = unpacked_a.sign;
      end
   end

   //////////////////////////////
   // Registers
   //////////////////////////////

   always_ff @(posedge Clk_CI, negedge Rst_RBI)
   begin
      if (~Rst_RBI)
      begin
         class_a <= '0;
         class_b <= '0;
         snan    <= 1'b0;
         sign_z  <= 1'b0;
         rm_dly  <= '0;
         norm_a  <= '0;
         norm_b  <= '0;
      end
      else if (accept)
      begin
         class_a <= class_a_next;
         class_b <= class_b_next;
         snan    <= snan_next;
         sign_z  <= sign_next;
         rm_dly  <= rm;
         norm_a  <= normed_a;
         norm_b  <= normed_b;
      end
   end

endmodule

//--- test/tb_ref_model.svh
//////////////////////////////
// Reference functions for classes, normalization and result sign
//////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Exponent field width per format
function automatic int fmt_exp_bits(input div_sqrt_pkg::fmt_sel_e fmt);
   case (fmt)
      div_sqrt_pkg::fmt_fp32: return 8;
      div_sqrt_pkg::fmt_fp64: return 11;
      div_sqrt_pkg::fmt_fp16: return 5;
      default:                return 8;
   endcase
endfunction

// Fraction field width per format
function automatic int fmt_frac_bits(input div_sqrt_pkg::fmt_sel_e fmt);
   case (fmt)
      div_sqrt_pkg::fmt_fp32: return 23;
      div_sqrt_pkg::fmt_fp64: return 52;
      div_sqrt_pkg::fmt_fp16: return 10;
      default:                return 7;
   endcase
endfunction

function automatic logic field_sign(input logic [63:0] op, input div_sqrt_pkg::fmt_sel_e fmt);
   return op[fmt_exp_bits(fmt) + fmt_frac_bits(fmt)];
endfunction

// Biased exponent, zero-extended to 11 bits
function automatic logic [10:0] field_exp(input logic [63:0] op,
                                          input div_sqrt_pkg::fmt_sel_e fmt);
   logic [63:0] mask;
   mask = (64'd1 << fmt_exp_bits(fmt)) - 64'd1;
   return 11'((op >> fmt_frac_bits(fmt)) & mask);
endfunction

// Fraction moved to the top of a 52-bit field
function automatic logic [51:0] field_frac(input logic [63:0] op,
                                           input div_sqrt_pkg::fmt_sel_e fmt);
   logic [63:0] mask;
   mask = (64'd1 << fmt_frac_bits(fmt)) - 64'd1;
   return 52'((op & mask) << (52 - fmt_frac_bits(fmt)));
endfunction

function automatic logic exp_is_max(input logic [63:0] op, input div_sqrt_pkg::fmt_sel_e fmt);
   return field_exp(op, fmt) == 11'((64'd1 << fmt_exp_bits(fmt)) - 64'd1);
endfunction

function automatic div_sqrt_pkg::op_class_t ref_class(input logic [63:0] op,
                                                      input div_sqrt_pkg::fmt_sel_e fmt);
   div_sqrt_pkg::op_class_t cls;
   cls.zero = (field_exp(op, fmt) == '0) && (field_frac(op, fmt) == '0);
   cls.inf  = exp_is_max(op, fmt) && (field_frac(op, fmt) == '0);
   cls.nan  = exp_is_max(op, fmt) && (field_frac(op, fmt) != '0);
   return cls;
endfunction

// NaN with quiet bit clear and a nonzero payload below it
function automatic logic ref_snan(input logic [63:0] op, input div_sqrt_pkg::fmt_sel_e fmt);
   logic [51:0] frac;
   frac = field_frac(op, fmt);
   return ref_class(op, fmt).nan && !frac[51] && (frac[50:0] != '0);
endfunction

// Shift to a leading one, one exponent step per shift, denormals count from one
function automatic div_sqrt_pkg::norm_op_t ref_norm(input logic [63:0] op,
                                                    input div_sqrt_pkg::fmt_sel_e fmt);
   div_sqrt_pkg::norm_op_t res;
   logic [10:0] e;
   logic [52:0] m;
   int          shifts;
   e      = field_exp(op, fmt);
   m      = {|e, field_frac(op, fmt)};
   shifts = 0;
   if (m != '0)
   begin
      while (!m[52])
      begin
         m = m << 1;
         shifts++;
      end
   end
   res.mant = m;
   res.exp  = {1'b0, e} - 12'(shifts) + ((shifts != 0) ? 12'd1 : 12'd0);
   return res;
endfunction

// Divide sign is the XOR, square root keeps the sign of a
function automatic logic ref_sign(input logic [63:0] a, input logic [63:0] b,
                                  input div_sqrt_pkg::fmt_sel_e fmt, input logic is_div);
   if (is_div)
   begin
      return field_sign(a, fmt) ^ field_sign(b, fmt);
   end
   return field_sign(a, fmt);
endfunction

`endif

//--- test/tb_div_sqrt_prep.sv
//////////////////////////////
// Testbench for the operand preparation stage
//////////////////////////////

module tb_div_sqrt_prep;
   timeunit 1ns;
   timeprecision 1ps;

   `include "tb_ref_model.svh"

   // About 2050 cycles of stimulus plus margin
   localparam int timeout_cycles = 6000;

   logic                    Clk_CI;
   logic                    Rst_RBI;
   logic                    div_start;
   logic                    sqrt_start;
   logic                    ready;
   logic [63:0]             operand_a;
   logic [63:0]             operand_b;
   logic [2:0]              rm;
   div_sqrt_pkg::fmt_sel_e  fmt_sel;
   div_sqrt_pkg::op_class_t class_a;
   div_sqrt_pkg::op_class_t class_b;
   logic                    snan;
   logic                    sign_z;
   logic [2:0]              rm_dly;
   div_sqrt_pkg::norm_op_t  norm_a;
   div_sqrt_pkg::norm_op_t  norm_b;

   // Expected state, loaded on each accept like the DUT registers
   div_sqrt_pkg::op_class_t exp_class_a;
   div_sqrt_pkg::op_class_t exp_class_b;
   logic                    exp_snan;
   logic                    exp_sign;
   logic [2:0]              exp_rm;
   div_sqrt_pkg::norm_op_t  exp_norm_a;
   div_sqrt_pkg::norm_op_t  exp_norm_b;

   int    seed;
   int    error_count  = 0;
   int    accept_count = 0;
   int    cycle_count  = 0;
   string test_name    = "reset";

   div_sqrt_prep DUT (
      .Clk_CI, .Rst_RBI, .div_start, .sqrt_start, .ready, .operand_a, .operand_b,
      .rm, .fmt_sel, .class_a, .class_b, .snan, .sign_z, .rm_dly, .norm_a, .norm_b
   );

   always #2 Clk_CI = ~Clk_CI;

   //////////////////////////////
   // Helpers
   //////////////////////////////

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // Builds an operand from raw fields of the given format
   function automatic logic [63:0] make_op(input div_sqrt_pkg::fmt_sel_e fmt, input logic sgn,
                                           input logic [10:0] e, input logic [51:0] f);
      int eb;
      int fb;
      eb = fmt_exp_bits(fmt);
      fb = fmt_frac_bits(fmt);
      return (64'(sgn) << (eb + fb)) | ((64'(e) & ((64'd1 << eb) - 64'd1)) << fb)
             | (64'(f) & ((64'd1 << fb) - 64'd1));
   endfunction

   // Zeros, infinities, NaNs, one and denormal corners
   function automatic logic [63:0] special_op(input div_sqrt_pkg::fmt_sel_e fmt, input int k);
      int          fb;
      logic [10:0] emax;
      logic [10:0] bias;
      fb   = fmt_frac_bits(fmt);
      emax = 11'((64'd1 << fmt_exp_bits(fmt)) - 64'd1);
      bias = emax >> 1;
      case (k)
         0:       return make_op(fmt, 1'b0, 11'd0, 52'd0);
         1:       return make_op(fmt, 1'b1, 11'd0, 52'd0);
         2:       return make_op(fmt, 1'b0, emax, 52'd0);
         3:       return make_op(fmt, 1'b1, emax, 52'd0);
         4:       return make_op(fmt, 1'b0, emax, 52'd1 << (fb - 1));
         5:       return make_op(fmt, 1'b1, emax, 52'd1);
         6:       return make_op(fmt, 1'b0, bias, 52'd0);
         7:       return make_op(fmt, 1'b0, 11'd0, 52'd1);
         default: return make_op(fmt, 1'b1, 11'd0, (52'd1 << fb) - 52'd1);
      endcase
   endfunction

   // Drives one cycle of inputs on the rising edge
   task automatic issue_op(input logic [63:0] a, input logic [63:0] b,
                           input div_sqrt_pkg::fmt_sel_e fmt, input logic div_s,
                           input logic sqrt_s, input logic rdy);
      @(posedge Clk_CI);
      operand_a  <= a;
      operand_b  <= b;
      fmt_sel    <= fmt;
      div_start  <= div_s;
      sqrt_start <= sqrt_s;
      ready      <= rdy;
      rm         <= 3'(rand_below(8));
   endtask

   task automatic report_mismatch(input string what, input logic [64:0] expv,
                                  input logic [64:0] actv);
      error_count++;
      $display("** Error: %s %s expected %h actual %h", test_name, what, expv, actv);
   endtask

   //////////////////////////////
   // Expected state
   //////////////////////////////

   always @(posedge Clk_CI or negedge Rst_RBI)
   begin
      if (!Rst_RBI)
      begin
         exp_class_a <= '0;
         exp_class_b <= '0;
         exp_snan    <= 1'b0;
         exp_sign    <= 1'b0;
         exp_rm      <= '0;
         exp_norm_a  <= '0;
         exp_norm_b  <= '0;
      end
      else if (ready && (div_start || sqrt_start))
      begin
         exp_class_a <= ref_class(operand_a, fmt_sel);
         exp_class_b <= ref_class(operand_b, fmt_sel);
         exp_snan    <= ref_snan(operand_a, fmt_sel) || ref_snan(operand_b, fmt_sel);
         exp_sign    <= ref_sign(operand_a, operand_b, fmt_sel, div_start);
         exp_rm      <= rm;
         exp_norm_a  <= ref_norm(operand_a, fmt_sel);
         exp_norm_b  <= ref_norm(operand_b, fmt_sel);
         accept_count++;
      end
   end

   //////////////////////////////
   // Output checks
   //////////////////////////////

   // Held state compared on every cycle, which also covers hold and post-reset zeros
   chk_class_a: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) class_a === exp_class_a)
      else report_mismatch("class_a", $sampled(exp_class_a), $sampled(class_a));
   chk_class_b: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) class_b === exp_class_b)
      else report_mismatch("class_b", $sampled(exp_class_b), $sampled(class_b));
   chk_snan: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) snan === exp_snan)
      else report_mismatch("snan", $sampled(exp_snan), $sampled(snan));
   chk_sign: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) sign_z === exp_sign)
      else report_mismatch("sign_z", $sampled(exp_sign), $sampled(sign_z));
   chk_rm: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) rm_dly === exp_rm)
      else report_mismatch("rm_dly", $sampled(exp_rm), $sampled(rm_dly));
   chk_norm_a: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) norm_a === exp_norm_a)
      else report_mismatch("norm_a", $sampled(exp_norm_a), $sampled(norm_a));
   chk_norm_b: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI) norm_b === exp_norm_b)
      else report_mismatch("norm_b", $sampled(exp_norm_b), $sampled(norm_b));

   //////////////////////////////
   // Timeout
   //////////////////////////////

   always @(posedge Clk_CI)
   begin
      cycle_count++;
      if (cycle_count >= timeout_cycles)
      begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display("Test failed");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial
   begin
      div_sqrt_pkg::fmt_sel_e fmt;
      logic [10:0]            emax;
      logic [51:0]            frac;
      int unsigned            pick;
      seed       = 32'hd162;
      Clk_CI     = 1'b0;
      Rst_RBI    = 1'b0;
      div_start  = 1'b0;
      sqrt_start = 1'b0;
      ready      = 1'b0;
      operand_a  = '0;
      operand_b  = '0;
      rm         = '0;
      fmt_sel    = div_sqrt_pkg::fmt_fp32;
      repeat (16) @(posedge Clk_CI);
      Rst_RBI <= 1'b1;
      repeat (3) @(posedge Clk_CI);

      // All pairs of special values per format
      test_name = "classify";
      for (int f = 0; f < 4; f++)
      begin
         fmt = div_sqrt_pkg::fmt_sel_e'(f);
         for (int i = 0; i < 9; i++)
         begin
            for (int j = 0; j < 9; j++)
            begin
               issue_op(special_op(fmt, i), special_op(fmt, j), fmt, (j % 2) == 0,
                        ((j % 2) != 0) || ((i % 3) == 0), 1'b1);
            end
         end
      end

      // Biased exponent strictly between zero and all ones
      test_name = "normals";
      for (int n = 0; n < 400; n++)
      begin
         fmt  = div_sqrt_pkg::fmt_sel_e'(n % 4);
         emax = 11'((64'd1 << fmt_exp_bits(fmt)) - 64'd1);
         issue_op(make_op(fmt, 1'(rand_below(2)), 11'(1 + rand_below(emax - 1)),
                          52'({$random(seed), $random(seed)})),
                  make_op(fmt, 1'(rand_below(2)), 11'(1 + rand_below(emax - 1)),
                          52'({$random(seed), $random(seed)})),
                  fmt, 1'b1, 1'b0, 1'b1);
      end

      // Single set bits, random fractions and a few zeros
      test_name = "denormals";
      for (int n = 0; n < 400; n++)
      begin
         fmt  = div_sqrt_pkg::fmt_sel_e'(n % 4);
         frac = (n % 3 == 0) ? (52'd1 << rand_below(fmt_frac_bits(fmt)))
                             : 52'({$random(seed), $random(seed)});
         if (n % 10 == 0)
         begin
            frac = '0;
         end
         issue_op(make_op(fmt, 1'(rand_below(2)), 11'd0, frac),
                  make_op(fmt, 1'(rand_below(2)), 11'd0,
                          52'({$random(seed), $random(seed)})),
                  fmt, 1'b0, 1'b1, 1'b1);
      end

      // Div only, sqrt only and both starts together
      test_name = "sign_rm";
      for (int n = 0; n < 400; n++)
      begin
         pick = rand_below(3);
         issue_op({$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                  div_sqrt_pkg::fmt_sel_e'(rand_below(4)), pick != 1, pick != 0, 1'b1);
      end

      // Ready and starts at random with mostly idle cycles
      test_name = "hold";
      for (int n = 0; n < 500; n++)
      begin
         issue_op({$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                  div_sqrt_pkg::fmt_sel_e'(rand_below(4)), rand_below(4) == 0,
                  rand_below(4) == 0, rand_below(2) == 0);
      end
      issue_op('0, '0, div_sqrt_pkg::fmt_fp32, 1'b0, 1'b0, 1'b0);
      repeat (3) @(posedge Clk_CI);

      $display("Run done: %0d errors, %0d accepts, %0d cycles",
               error_count, accept_count, cycle_count);
      if (error_count == 0)
      begin
         $display("Test completed successfully");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
